// File: logic/plic_pkg.sv
package plic_pkg;

    // source 0 is reserved and never raises a request
    localparam int NUM_SRC = 32;
    localparam int NUM_CTX = 4;

    // widths of the typed vectors below
    localparam int SRC_ID_W = 5;
    localparam int PRIO_W   = 4;
    localparam int CTX_ID_W = 2;
    localparam int ADDR_W   = 10;
    localparam int DATA_W   = 32;

    typedef logic [SRC_ID_W-1:0] src_id_t;
    typedef logic [PRIO_W-1:0]   prio_t;
    typedef logic [CTX_ID_W-1:0] ctx_id_t;
    typedef logic [ADDR_W-1:0]   reg_addr_t;
    typedef logic [DATA_W-1:0]   reg_data_t;
    typedef logic [NUM_SRC-1:0]  src_vec_t;
    typedef logic [NUM_CTX-1:0]  ctx_vec_t;
    typedef prio_t [NUM_SRC-1:0] prio_arr_t;

    // byte address map, one 32-bit register per word
    localparam reg_addr_t PRIO_BASE   = 10'h000;
    localparam reg_addr_t PEND_BASE   = 10'h100;
    localparam reg_addr_t ENABLE_BASE = 10'h200;
    localparam reg_addr_t THRESH_BASE = 10'h300;
    // claim/complete sits one word above each threshold
    localparam reg_addr_t CLAIM_BASE  = 10'h304;

    typedef enum logic [2:0] {
        REG_NONE,
        REG_PRIO,
        REG_PEND,
        REG_ENABLE,
        REG_THRESH,
        REG_CLAIM
    } reg_region_e;

endpackage

// File: logic/plic_reg_if.sv
`timescale 1ns/100ps

// one decoded register access, valid in the cycle of the request
interface plic_reg_if
    import plic_pkg::*;
();

    logic        rd;
    logic        wr;
    reg_region_e region;
    // source number for priorities, context number otherwise
    logic [4:0]  index;
    reg_data_t   wdata;

    modport dec (
        output rd,
        output wr,
        output region,
        output index,
        output wdata
    );

    modport sink (
        input rd,
        input wr,
        input region,
        input index,
        input wdata
    );

endinterface

// File: logic/plic_reg_decode.sv
`timescale 1ns/100ps

module plic_reg_decode
    import plic_pkg::*;
(
    input  logic       clk,
    input  logic       nrst,
    input  logic       i_req_valid,
    input  logic       i_req_write,
    input  reg_addr_t  i_req_addr,
    input  reg_data_t  i_req_wdata,
    output prio_arr_t  o_prio,
    output src_vec_t   o_enable [NUM_CTX],
    output prio_t      o_thresh [NUM_CTX],
    plic_reg_if.dec    bus
);

    reg_region_e region;
    logic [4:0]  index;
    ctx_id_t     ctx;
    logic        wr_en;

    prio_arr_t   prio_q;
    src_vec_t    enable_q [NUM_CTX];
    prio_t       thresh_q [NUM_CTX];

    // split the address into region and index
    always_comb begin
        region = REG_NONE;
        index  = '0;
        case (i_req_addr[9:8])
            PRIO_BASE[9:8]: begin
                // only the first 32 words hold priorities
                if (!i_req_addr[7]) begin
                    region = REG_PRIO;
                    index  = i_req_addr[6:2];
                end
            end
            PEND_BASE[9:8]: begin
                if (i_req_addr[7:2] == '0) begin
                    region = REG_PEND;
                end
            end
            ENABLE_BASE[9:8]: begin
                if (i_req_addr[7:4] == '0) begin
                    region = REG_ENABLE;
                    index  = {3'b000, i_req_addr[3:2]};
                end
            end
            THRESH_BASE[9:8]: begin
                // threshold and claim words alternate per context
                if (i_req_addr[7:5] == '0) begin
                    region = (i_req_addr[2] == CLAIM_BASE[2]) ? REG_CLAIM : REG_THRESH;
                    index  = {3'b000, i_req_addr[4:3]};
                end
            end
            default: region = REG_NONE;
        endcase
    end

    assign ctx   = index[1:0];
    assign wr_en = i_req_valid & i_req_write;

    assign bus.rd     = i_req_valid & ~i_req_write;
    assign bus.wr     = wr_en;
    assign bus.region = region;
    assign bus.index  = index;
    assign bus.wdata  = i_req_wdata;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            prio_q <= '0;
            for (int c = 0; c < NUM_CTX; c++) begin
                enable_q[c] <= '0;
                thresh_q[c] <= '0;
            end
        end else if (wr_en) begin
            case (region)
                REG_PRIO: begin
                    // priority of source 0 stays zero
                    if (index != '0) begin
                        prio_q[index] <= i_req_wdata[PRIO_W-1:0];
                    end
                end
                // enable bit 0 is hardwired low
                REG_ENABLE: enable_q[ctx] <= {i_req_wdata[NUM_SRC-1:1], 1'b0};
                REG_THRESH: thresh_q[ctx] <= i_req_wdata[PRIO_W-1:0];
                default: ;
            endcase
        end
    end

    assign o_prio   = prio_q;
    assign o_enable = enable_q;
    assign o_thresh = thresh_q;

endmodule

// File: logic/plic_gateway.sv
`timescale 1ns/100ps

module plic_gateway
    import plic_pkg::*;
(
    input  logic       clk,
    input  logic       nrst,
    input  src_vec_t   i_irq,
    input  prio_arr_t  i_prio,
    input  src_id_t    i_claim_id [NUM_CTX],
    plic_reg_if.sink   bus,
    output src_vec_t   o_pending
);

    src_vec_t pending_q;
    src_vec_t in_service_q;
    src_vec_t req_set;
    src_vec_t claim_hit;
    src_vec_t complete_hit;
    src_id_t  claim_src;
    src_id_t  complete_src;
    ctx_id_t  ctx;

    assign ctx          = bus.index[1:0];
    assign claim_src    = i_claim_id[ctx];
    assign complete_src = bus.wdata[SRC_ID_W-1:0];

    // level requests are gated by priority and in-service state
    always_comb begin
        req_set = '0;
        for (int s = 1; s < NUM_SRC; s++) begin
            req_set[s] = i_irq[s] && (i_prio[s] != '0) && !in_service_q[s];
        end
    end

    // claim read of a context moves its current winner to in service
    always_comb begin
        claim_hit = '0;
        if (bus.rd && (bus.region == REG_CLAIM) && (claim_src != '0)) begin
            claim_hit[claim_src] = 1'b1;
        end
    end

    // complete write releases the source named in the data
    always_comb begin
        complete_hit = '0;
        if (bus.wr && (bus.region == REG_CLAIM) && (complete_src != '0)) begin
            complete_hit[complete_src] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pending_q    <= '0;
            in_service_q <= '0;
        end else begin
            // claim wins over a request seen at the same edge
            pending_q    <= (pending_q | req_set) & ~claim_hit;
            in_service_q <= (in_service_q | claim_hit) & ~complete_hit;
        end
    end

    assign o_pending = pending_q;

endmodule

// File: logic/plic_arbiter.sv
`timescale 1ns/100ps

module plic_arbiter
    import plic_pkg::*;
(
    input  logic       clk,
    input  logic       nrst,
    input  src_vec_t   i_pending,
    input  prio_arr_t  i_prio,
    input  src_vec_t   i_enable [NUM_CTX],
    input  prio_t      i_thresh [NUM_CTX],
    output src_id_t    o_claim_id [NUM_CTX],
    output ctx_vec_t   o_ip
);

    // running best per context while scanning the sources
    prio_t    best_prio [NUM_CTX];
    src_id_t  best_id   [NUM_CTX];
    src_vec_t eligible  [NUM_CTX];

    src_id_t  claim_id_q [NUM_CTX];
    ctx_vec_t ip_q;

    always_comb begin
        for (int c = 0; c < NUM_CTX; c++) begin
            eligible[c] = i_pending & i_enable[c];
        end
    end

    // starting from the threshold makes one compare cover both rules
    // strict compare keeps the lowest id on equal priority
    always_comb begin
        for (int c = 0; c < NUM_CTX; c++) begin
            best_prio[c] = i_thresh[c];
            best_id[c]   = '0;
            for (int s = 1; s < NUM_SRC; s++) begin
                if (eligible[c][s] && (i_prio[s] > best_prio[c])) begin
                    best_prio[c] = i_prio[s];
                    best_id[c]   = src_id_t'(s);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ip_q <= '0;
            for (int c = 0; c < NUM_CTX; c++) begin
                claim_id_q[c] <= '0;
            end
        end else begin
            for (int c = 0; c < NUM_CTX; c++) begin
                claim_id_q[c] <= best_id[c];
                ip_q[c]       <= (best_id[c] != '0);
            end
        end
    end

    assign o_claim_id = claim_id_q;
    assign o_ip       = ip_q;

endmodule

// File: logic/plic_read_mux.sv
`timescale 1ns/100ps

module plic_read_mux
    import plic_pkg::*;
(
    input  logic       clk,
    input  logic       nrst,
    plic_reg_if.sink   bus,
    input  prio_arr_t  i_prio,
    input  src_vec_t   i_pending,
    input  src_vec_t   i_enable [NUM_CTX],
    input  prio_t      i_thresh [NUM_CTX],
    input  src_id_t    i_claim_id [NUM_CTX],
    output logic       o_resp_valid,
    output reg_data_t  o_resp_rdata
);

    ctx_id_t   ctx;
    reg_data_t rdata_d;
    reg_data_t rdata_q;
    logic      valid_q;

    assign ctx = bus.index[1:0];

    // narrow registers are zero extended, unmapped space reads zero
    always_comb begin
        rdata_d = '0;
        case (bus.region)
            REG_PRIO:   rdata_d[PRIO_W-1:0]   = i_prio[bus.index];
            REG_PEND:   rdata_d               = i_pending;
            REG_ENABLE: rdata_d               = i_enable[ctx];
            REG_THRESH: rdata_d[PRIO_W-1:0]   = i_thresh[ctx];
            REG_CLAIM:  rdata_d[SRC_ID_W-1:0] = i_claim_id[ctx];
            default:    rdata_d               = '0;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= bus.rd;
        end
    end

    // read data only moves on a read
    always_ff @(posedge clk) begin
        if (bus.rd) begin
            rdata_q <= rdata_d;
        end
    end

    assign o_resp_valid = valid_q;
    assign o_resp_rdata = rdata_q;

endmodule

// File: logic/plic_top.sv
`timescale 1ns/100ps

module plic_top
    import plic_pkg::*;
(
    input  logic       clk,
    input  logic       nrst,
    input  src_vec_t   i_irq,
    input  logic       i_req_valid,
    input  logic       i_req_write,
    input  reg_addr_t  i_req_addr,
    input  reg_data_t  i_req_wdata,
    output logic       o_resp_valid,
    output reg_data_t  o_resp_rdata,
    output ctx_vec_t   o_ip
);

    prio_arr_t prio;
    src_vec_t  enable   [NUM_CTX];
    prio_t     thresh   [NUM_CTX];
    src_vec_t  pending;
    src_id_t   claim_id [NUM_CTX];

    // decoded access shared by all execute and result blocks
    plic_reg_if reg_bus ();

    plic_reg_decode u_decode (
        .clk         (clk),
        .nrst        (nrst),
        .i_req_valid (i_req_valid),
        .i_req_write (i_req_write),
        .i_req_addr  (i_req_addr),
        .i_req_wdata (i_req_wdata),
        .o_prio      (prio),
        .o_enable    (enable),
        .o_thresh    (thresh),
        .bus         (reg_bus)
    );

    plic_gateway u_gateway (
        .clk        (clk),
        .nrst       (nrst),
        .i_irq      (i_irq),
        .i_prio     (prio),
        .i_claim_id (claim_id),
        .bus        (reg_bus),
        .o_pending  (pending)
    );

    plic_arbiter u_arbiter (
        .clk        (clk),
        .nrst       (nrst),
        .i_pending  (pending),
        .i_prio     (prio),
        .i_enable   (enable),
        .i_thresh   (thresh),
        .o_claim_id (claim_id),
        .o_ip       (o_ip)
    );

    plic_read_mux u_read_mux (
        .clk          (clk),
        .nrst         (nrst),
        .bus          (reg_bus),
        .i_prio       (prio),
        .i_pending    (pending),
        .i_enable     (enable),
        .i_thresh     (thresh),
        .i_claim_id   (claim_id),
        .o_resp_valid (o_resp_valid),
        .o_resp_rdata (o_resp_rdata)
    );

endmodule

// File: bench/plic_model.svh
`ifndef PLIC_MODEL_SVH
`define PLIC_MODEL_SVH

// shadow of the configuration and of the gateway state
prio_arr_t m_prio;
src_vec_t  m_enable [NUM_CTX];
prio_t     m_thresh [NUM_CTX];
src_vec_t  m_pending;
src_vec_t  m_in_service;

function automatic void model_clear();
    m_prio       = '0;
    m_pending    = '0;
    m_in_service = '0;
    for (int c = 0; c < NUM_CTX; c++) begin
        m_enable[c] = '0;
        m_thresh[c] = '0;
    end
endfunction

// downward scan with >= so that a tie ends on the lower id
function automatic src_id_t expected_claim(ctx_id_t c);
    prio_t   best;
    src_id_t id;
    best = '0;
    id   = '0;
    for (int s = NUM_SRC - 1; s > 0; s--) begin
        if (m_pending[s] && m_enable[c][s] &&
            (m_prio[s] > m_thresh[c]) && (m_prio[s] >= best)) begin
            best = m_prio[s];
            id   = src_id_t'(s);
        end
    end
    return id;
endfunction

function automatic reg_data_t expected_read(reg_addr_t addr);
    reg_data_t d;
    d = '0;
    if (addr < 10'h080) d[3:0] = m_prio[addr[6:2]];
    else if (addr == PEND_BASE) d = m_pending;
    else if ((addr >= ENABLE_BASE) && (addr < 10'h210)) d = m_enable[addr[3:2]];
    else if ((addr >= THRESH_BASE) && (addr < 10'h320)) begin
        // odd words are the claim registers
        if (addr[2]) d[4:0] = expected_claim(addr[4:3]);
        else d[3:0] = m_thresh[addr[4:3]];
    end
    return d;
endfunction

function automatic void model_write(reg_addr_t addr, reg_data_t data);
    if ((addr < 10'h080) && (addr[6:2] != 5'd0)) m_prio[addr[6:2]] = data[3:0];
    else if ((addr >= ENABLE_BASE) && (addr < 10'h210)) m_enable[addr[3:2]] = data & ~32'd1;
    else if ((addr >= THRESH_BASE) && (addr < 10'h320)) begin
        if (addr[2]) m_in_service[data[4:0]] = 1'b0;
        else m_thresh[addr[4:3]] = data[3:0];
    end
endfunction

function automatic void model_claim(src_id_t id);
    if (id != '0) begin
        m_pending[id]    = 1'b0;
        m_in_service[id] = 1'b1;
    end
endfunction

function automatic void model_latch_requests(src_vec_t irq);
    for (int s = 1; s < NUM_SRC; s++) begin
        if (irq[s] && (m_prio[s] != '0) && !m_in_service[s]) m_pending[s] = 1'b1;
    end
endfunction

`endif

// File: bench/plic_tb.sv
`timescale 1ns/100ps

module plic_tb
    import plic_pkg::*;
();

    localparam int CLK_PERIOD = 10;
    // upper bound on accesses and settle waits over all tests
    localparam int NUM_STEPS  = 640;

    logic      clk = 1'b0;
    logic      nrst = 1'b0;
    src_vec_t  i_irq = '0;
    logic      i_req_valid = 1'b0;
    logic      i_req_write = 1'b0;
    reg_addr_t i_req_addr = '0;
    reg_data_t i_req_wdata = '0;
    logic      o_resp_valid;
    reg_data_t o_resp_rdata;
    ctx_vec_t  o_ip;
    integer    seed = 32'h8aae;

    `include "plic_model.svh"

    plic_top i_plic_top (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_data(string name, reg_data_t got, reg_data_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_ip(string name, ctx_vec_t got, ctx_vec_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_id(string name, src_id_t got, src_id_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    // a write must not raise a read response in the following cycle
    task automatic reg_write(int addr, reg_data_t data);
        @(posedge clk);
        i_req_valid <= 1'b1;
        i_req_write <= 1'b1;
        i_req_addr  <= reg_addr_t'(addr);
        i_req_wdata <= data;
        @(posedge clk);
        i_req_valid <= 1'b0;
        model_write(reg_addr_t'(addr), data);
        @(negedge clk);
        if (o_resp_valid !== 1'b0) begin
            $display("read response is high after a write request");
            abort_run();
        end
    endtask

    // response is due in the one cycle after the sampling edge
    task automatic reg_read(input int addr, output reg_data_t data);
        @(posedge clk);
        i_req_valid <= 1'b1;
        i_req_write <= 1'b0;
        i_req_addr  <= reg_addr_t'(addr);
        @(negedge clk);
        if (o_resp_valid !== 1'b0) begin
            $display("read response is high outside its single cycle");
            abort_run();
        end
        @(posedge clk);
        i_req_valid <= 1'b0;
        @(negedge clk);
        if (o_resp_valid !== 1'b1) begin
            $display("no read response in the cycle after the request");
            abort_run();
        end
        data = o_resp_rdata;
    endtask

    task automatic read_check(int addr);
        reg_data_t exp;
        reg_data_t got;
        exp = expected_read(reg_addr_t'(addr));
        reg_read(addr, got);
        check_data("o_resp_rdata", got, exp);
    endtask

    task automatic claim_check(int c);
        reg_data_t got;
        src_id_t   exp;
        exp = expected_claim(ctx_id_t'(c));
        reg_read(int'(CLAIM_BASE) + 8 * c, got);
        check_id("claim id", src_id_t'(got), exp);
        model_claim(exp);
    endtask

    task automatic set_irq(src_vec_t v);
        @(posedge clk);
        i_irq <= v;
    endtask

    // one edge to latch pending, one more for the arbiter register
    task automatic settle_check();
        ctx_vec_t exp;
        repeat (2) @(posedge clk);
        @(negedge clk);
        model_latch_requests(i_irq);
        for (int c = 0; c < NUM_CTX; c++) begin
            exp[c] = (expected_claim(ctx_id_t'(c)) != '0);
        end
        check_ip("o_ip", o_ip, exp);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        nrst  <= 1'b0;
        i_irq <= '0;
        repeat (8) @(posedge clk);
        nrst <= 1'b1;
        model_clear();
    endtask

    // all mapped registers and a few unmapped words
    task automatic read_all();
        for (int s = 0; s < NUM_SRC; s++) read_check(4 * s);
        read_check(int'(PEND_BASE));
        for (int c = 0; c < NUM_CTX; c++) begin
            read_check(int'(ENABLE_BASE) + 4 * c);
            read_check(int'(THRESH_BASE) + 8 * c);
            read_check(int'(CLAIM_BASE) + 8 * c);
        end
        read_check('h080);
        read_check('h104);
        read_check('h210);
        read_check('h3fc);
    endtask

    initial begin
        apply_reset();
        @(negedge clk);
        check_ip("o_ip", o_ip, '0);
        read_all();
        for (int s = 0; s < NUM_SRC; s++) reg_write(4 * s, $random(seed));
        for (int c = 0; c < NUM_CTX; c++) begin
            reg_write(int'(ENABLE_BASE) + 4 * c, $random(seed));
            reg_write(int'(THRESH_BASE) + 8 * c, $random(seed));
        end
        read_all();

        apply_reset();
        reg_write(4 * 5, 32'd2);
        set_irq(32'h0000_0029);  // sources 0, 3 and 5
        settle_check();
        read_check(int'(PEND_BASE));

        // narrow priority range so that ties are common
        repeat (8) begin
            apply_reset();
            for (int s = 1; s < NUM_SRC; s++) reg_write(4 * s, $random(seed) & 7);
            for (int c = 0; c < NUM_CTX; c++) begin
                reg_write(int'(ENABLE_BASE) + 4 * c, $random(seed));
                reg_write(int'(THRESH_BASE) + 8 * c, $random(seed) & 7);
            end
            set_irq($random(seed));
            settle_check();
            read_check(int'(PEND_BASE));
            for (int c = 0; c < NUM_CTX; c++) begin
                claim_check(c);
                settle_check();
            end
        end

        // held requests stay blocked while in service
        apply_reset();
        reg_write(4 * 4, 32'd3);
        reg_write(4 * 7, 32'd5);
        reg_write(4 * 9, 32'd5);
        reg_write(int'(ENABLE_BASE), 32'h0000_0290);
        set_irq(32'h0000_0290);
        settle_check();
        repeat (3) begin
            claim_check(0);
            settle_check();
            read_check(int'(PEND_BASE));
        end
        reg_write(int'(CLAIM_BASE), 32'd7);
        settle_check();
        read_check(int'(PEND_BASE));
        claim_check(0);

        // contexts 1 and 2 share sources, context 2 has threshold 5
        apply_reset();
        reg_write(4 * 2, 32'd5);
        reg_write(4 * 6, 32'd6);
        reg_write(4 * 12, 32'd9);
        for (int c = 1; c < 3; c++) reg_write(int'(ENABLE_BASE) + 4 * c, 32'h0000_1044);
        reg_write(int'(THRESH_BASE) + 8 * 2, 32'd5);
        set_irq(32'h0000_1044);
        settle_check();
        claim_check(1);
        settle_check();
        claim_check(2);
        settle_check();
        claim_check(1);
        settle_check();

        $display("Simulation passed");
        $finish;
    end

    initial begin
        #((NUM_STEPS * 20 + 500) * CLK_PERIOD);
        $display("timeout: the tests did not complete in the expected time");
        abort_run();
    end

endmodule

// File: tb.f
+incdir+bench
logic/plic_pkg.sv
logic/plic_reg_if.sv
logic/plic_reg_decode.sv
logic/plic_gateway.sv
logic/plic_arbiter.sv
logic/plic_read_mux.sv
logic/plic_top.sv
bench/plic_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then decide on the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f tb.f --top-module plic_tb -o plic_sim &&
    ./obj_dir/plic_sim > sim.log 2>&1 ||
    echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "Simulation passed" sim.log && echo "PASS" && exit 0 ||
    { echo "FAIL"; exit 1; }
